/* hdl/sram_ctrl_pkg.sv */
package sram_ctrl_pkg;

  // command sequencer state
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_READ  = 2'd1,
    SEQ_WRITE = 2'd2
  } seq_state_e;

  // pad request strobes registered in the sequencer
  // and once more in the pad I/O before the pins
  typedef struct packed {
    // output enable, active low
    logic oe_n;
    // write enable, active low
    logic we_n;
    // tri-state data driver enable
    logic drive;
  } pad_ctrl_t;

  // all strobes released and the data bus floating
  localparam pad_ctrl_t PAD_CTRL_IDLE = '{oe_n: 1'b1, we_n: 1'b1, drive: 1'b0};

  // number of read responses the result FIFO can hold
  localparam int RESP_FIFO_DEPTH = 2;

endpackage

/* hdl/sram_cmd_sequencer.sv */
`timescale 1ns/10ps

module sram_cmd_sequencer
  import sram_ctrl_pkg::*;
#(
  parameter int ADDR_WIDTH  = 4,
  parameter int DATA_WIDTH  = 16,
  parameter int RDATA_WIDTH = 12
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // command port
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  logic [ADDR_WIDTH-1:0]  cmd_addr,
  input  logic                   cmd_wr_en,
  input  logic [DATA_WIDTH-1:0]  cmd_wr_data,

  // result FIFO holds at least one entry
  input  logic                   busy,

  // pad requests
  output logic [ADDR_WIDTH-1:0]  pad_addr,
  output logic [RDATA_WIDTH-1:0] pad_wr_data,
  output pad_ctrl_t              pad_ctrl
);

  // cycles from read acceptance to the FIFO write of its data
  // (sequencer reg, pad output reg, pad sample reg, rd_data reg)
  localparam int RD_LATENCY = 4;

  seq_state_e            state;
  seq_state_e            state_next;
  logic                  cmd_accept;
  logic                  ready_en;
  logic [RD_LATENCY-1:0] rd_track;

  assign cmd_accept = cmd_valid && cmd_ready;

  always_comb begin
    state_next = state;
    case (state)
      SEQ_IDLE: begin
        if (cmd_accept) begin
          if (cmd_wr_en) begin
            state_next = SEQ_WRITE;
          end else begin
            state_next = SEQ_READ;
          end
        end
      end
      SEQ_READ: begin
        state_next = SEQ_IDLE;
      end
      SEQ_WRITE: begin
        state_next = SEQ_IDLE;
      end
      default: begin
        state_next = SEQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= SEQ_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // keep cmd_ready low until the first cycle out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
    end
  end

  // one bit per accepted read still on its way to the FIFO
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_track <= '0;
    end else begin
      rd_track <= {rd_track[RD_LATENCY-2:0], cmd_accept && !cmd_wr_en};
    end
  end

  // an empty FIFO plus fewer than RESP_FIFO_DEPTH reads in flight
  // leaves room for one more read, even with resp_ready held low
  assign cmd_ready = ready_en && (state == SEQ_IDLE) && !busy &&
                     ($countones(rd_track) < RESP_FIFO_DEPTH);

  // address and write data only load on acceptance
  always_ff @(posedge clk) begin
    if (state_next != SEQ_IDLE && state == SEQ_IDLE) begin
      pad_addr <= cmd_addr;
    end
    if (state_next == SEQ_WRITE && state == SEQ_IDLE) begin
      // upper bits beyond the wired data lines are dropped
      pad_wr_data <= RDATA_WIDTH'(cmd_wr_data);
    end
  end

  // drive stays on one cycle past the write strobe so data
  // is still valid when we_n rises at the chip
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pad_ctrl <= PAD_CTRL_IDLE;
    end else begin
      pad_ctrl.oe_n  <= (state_next != SEQ_READ);
      pad_ctrl.we_n  <= (state_next != SEQ_WRITE);
      pad_ctrl.drive <= (state_next == SEQ_WRITE) || (state == SEQ_WRITE);
    end
  end

endmodule

/* hdl/sram_pad_io.sv */
`timescale 1ns/10ps

module sram_pad_io
  import sram_ctrl_pkg::*;
#(
  parameter int ADDR_WIDTH  = 4,
  parameter int RDATA_WIDTH = 12
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // requests from the sequencer
  input  logic [ADDR_WIDTH-1:0]  pad_addr,
  input  logic [RDATA_WIDTH-1:0] pad_wr_data,
  input  pad_ctrl_t              pad_ctrl,

  // captured read data
  output logic                   rd_valid,
  output logic [RDATA_WIDTH-1:0] rd_data,

  // chip pins
  output logic [ADDR_WIDTH-1:0]  sram_addr,
  inout  wire  [RDATA_WIDTH-1:0] sram_data,
  output logic                   sram_we_n,
  output logic                   sram_oe_n,
  output logic                   sram_ce_n
);

  logic                   drive_q;
  logic [RDATA_WIDTH-1:0] wr_data_q;
  logic [RDATA_WIDTH-1:0] rd_sample;

  // bit 0 marks the cycle rd_sample holds chip data
  // and bit 1 the cycle rd_data holds it
  logic [1:0]             rd_pipe;

  // output registers one cycle behind the request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_oe_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_ce_n <= 1'b1;
      drive_q   <= 1'b0;
    end else begin
      sram_oe_n <= pad_ctrl.oe_n;
      sram_we_n <= pad_ctrl.we_n;
      // chip selected for either access
      sram_ce_n <= pad_ctrl.oe_n && pad_ctrl.we_n;
      drive_q   <= pad_ctrl.drive;
    end
  end

  always_ff @(posedge clk) begin
    sram_addr <= pad_addr;
    wr_data_q <= pad_wr_data;
  end

  assign sram_data = drive_q ? wr_data_q : {RDATA_WIDTH{1'bz}};

  // input register right at the pins sampling every cycle
  always_ff @(posedge clk) begin
    rd_sample <= sram_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pipe <= 2'b00;
    end else begin
      rd_pipe <= {rd_pipe[0], !sram_oe_n};
    end
  end

  // sample taken while oe_n was low at the pins moves on to rd_data
  always_ff @(posedge clk) begin
    if (rd_pipe[0]) begin
      rd_data <= rd_sample;
    end
  end

  // one-cycle pulse alongside the captured word
  assign rd_valid = rd_pipe[1];

endmodule

/* hdl/sram_resp_fifo.sv */
`timescale 1ns/10ps

module sram_resp_fifo
  import sram_ctrl_pkg::*;
#(
  parameter int DATA_WIDTH  = 16,
  parameter int RDATA_WIDTH = 12
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // read data from the pad I/O
  input  logic                   wr_valid,
  input  logic [RDATA_WIDTH-1:0] wr_data,

  // back-pressure to the sequencer
  output logic                   busy,

  // response port
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output logic [DATA_WIDTH-1:0]  resp_data
);

  localparam int PTR_WIDTH = (RESP_FIFO_DEPTH > 1) ? $clog2(RESP_FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(RESP_FIFO_DEPTH + 1);

  logic [RDATA_WIDTH-1:0] mem [RESP_FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [CNT_WIDTH-1:0]   count;
  logic                   push;
  logic                   pop;

  // a push into a full FIFO is dropped
  assign push = wr_valid && (count != CNT_WIDTH'(RESP_FIFO_DEPTH));
  assign pop  = resp_valid && resp_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(RESP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(RESP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign busy       = (count != '0);
  assign resp_valid = (count != '0);

  // head entry zero-extended to the command data width
  // and held until popped
  assign resp_data = DATA_WIDTH'(mem[rd_ptr]);

endmodule

/* hdl/sram_ctrl_top.sv */
`timescale 1ns/10ps

module sram_ctrl_top
  import sram_ctrl_pkg::*;
#(
  parameter int ADDR_WIDTH  = 4,
  parameter int DATA_WIDTH  = 16,
  parameter int RDATA_WIDTH = 12
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // command port
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  logic [ADDR_WIDTH-1:0]  cmd_addr,
  input  logic                   cmd_wr_en,
  input  logic [DATA_WIDTH-1:0]  cmd_wr_data,

  // response port
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output logic [DATA_WIDTH-1:0]  resp_data,

  // async SRAM chip
  output logic [ADDR_WIDTH-1:0]  sram_addr,
  inout  wire  [RDATA_WIDTH-1:0] sram_data,
  output logic                   sram_we_n,
  output logic                   sram_oe_n,
  output logic                   sram_ce_n
);

  logic [ADDR_WIDTH-1:0]  pad_addr;
  logic [RDATA_WIDTH-1:0] pad_wr_data;
  pad_ctrl_t              pad_ctrl;
  logic                   rd_valid;
  logic [RDATA_WIDTH-1:0] rd_data;
  logic                   busy;

  sram_cmd_sequencer #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .RDATA_WIDTH (RDATA_WIDTH)
  ) u_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_addr    (cmd_addr),
    .cmd_wr_en   (cmd_wr_en),
    .cmd_wr_data (cmd_wr_data),
    .busy        (busy),
    .pad_addr    (pad_addr),
    .pad_wr_data (pad_wr_data),
    .pad_ctrl    (pad_ctrl)
  );

  sram_pad_io #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .RDATA_WIDTH (RDATA_WIDTH)
  ) u_pad_io (
    .clk         (clk),
    .rst_n       (rst_n),
    .pad_addr    (pad_addr),
    .pad_wr_data (pad_wr_data),
    .pad_ctrl    (pad_ctrl),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_ce_n   (sram_ce_n)
  );

  sram_resp_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .RDATA_WIDTH (RDATA_WIDTH)
  ) u_resp_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_valid    (rd_valid),
    .wr_data     (rd_data),
    .busy        (busy),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_data   (resp_data)
  );

endmodule

/* verification/async_sram_model.sv */
`timescale 1ns/10ps

module async_sram_model #(
  parameter int ADDR_WIDTH = 4,
  parameter int DATA_WIDTH = 12
) (
  input  logic [ADDR_WIDTH-1:0] addr,
  inout  wire  [DATA_WIDTH-1:0] data,
  input  logic                  we_n,
  input  logic                  oe_n,
  input  logic                  ce_n
);

  localparam int WORDS = 1 << ADDR_WIDTH;

  // only the wired data lines exist in the array
  logic [DATA_WIDTH-1:0] mem [WORDS];
  logic                  read_en;

  // chip drives the bus while selected and output enabled,
  // and never during a write strobe
  assign read_en = !ce_n && !oe_n && we_n;

  assign data = read_en ? mem[addr] : {DATA_WIDTH{1'bz}};

  // the write completes on the rising edge of we_n
  // and ce_n rises on that same edge in this controller so only we_n is watched
  always @(posedge we_n) begin
    if (!$isunknown(addr)) begin
      mem[addr] <= data;
    end
  end

endmodule

/* verification/sram_ctrl_tb.sv */
`timescale 1ns/10ps

module sram_ctrl_tb
  import sram_ctrl_pkg::*;
();

  localparam int ADDR_WIDTH  = 4;
  localparam int DATA_WIDTH  = 16;
  localparam int RDATA_WIDTH = 12;
  localparam int MEM_WORDS   = 1 << ADDR_WIDTH;

  // first cycle with resp_valid high as counted from the accepting edge
  localparam int READ_LATENCY_MAX = 4;
  // worst case is a full set of reads in flight draining through the FIFO
  localparam int CMD_WAIT_LIMIT   = 4 * (RESP_FIFO_DEPTH + 1);
  localparam int DRAIN_LIMIT      = 12;
  // the tests run for roughly 450 cycles
  localparam int TIMEOUT_CYCLES   = 2000;

  logic                   clk;
  logic                   rst_n;
  logic                   cmd_valid;
  logic                   cmd_ready;
  logic [ADDR_WIDTH-1:0]  cmd_addr;
  logic                   cmd_wr_en;
  logic [DATA_WIDTH-1:0]  cmd_wr_data;
  logic                   resp_valid;
  logic                   resp_ready;
  logic [DATA_WIDTH-1:0]  resp_data;
  logic [ADDR_WIDTH-1:0]  sram_addr;
  wire  [RDATA_WIDTH-1:0] sram_data;
  logic                   sram_we_n;
  logic                   sram_oe_n;
  logic                   sram_ce_n;

  // expected chip contents over the wired bits only
  logic [RDATA_WIDTH-1:0] ref_mem [MEM_WORDS];
  logic [DATA_WIDTH-1:0]  exp_data_q [$];
  int                     exp_cycle_q [$];
  int                     cycle_count;
  int                     resp_count;
  logic [31:0]            lfsr_state;
  bit                     head_seen;
  bit                     resp_held;
  logic [DATA_WIDTH-1:0]  held_data;
  seq_state_e             seq_state;

  sram_ctrl_top #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .RDATA_WIDTH (RDATA_WIDTH)
  ) u_sram_ctrl_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_addr    (cmd_addr),
    .cmd_wr_en   (cmd_wr_en),
    .cmd_wr_data (cmd_wr_data),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_data   (resp_data),
    .sram_addr   (sram_addr),
    .sram_data   (sram_data),
    .sram_we_n   (sram_we_n),
    .sram_oe_n   (sram_oe_n),
    .sram_ce_n   (sram_ce_n)
  );

  async_sram_model #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (RDATA_WIDTH)
  ) u_sram (
    .addr (sram_addr),
    .data (sram_data),
    .we_n (sram_we_n),
    .oe_n (sram_oe_n),
    .ce_n (sram_ce_n)
  );

  // sequencer state for failure messages
  assign seq_state = u_sram_ctrl_top.u_sequencer.state;

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("MISMATCH t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic check_condition(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR t=%0t %s", $time, what);
      $display("** FAIL **");
      $fatal(1, "check failed");
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1 in Galois form
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    check_condition(cycle_count < TIMEOUT_CYCLES,
                    $sformatf("run timed out after %0d cycles, sequencer in %s",
                              cycle_count, seq_state.name()));
  end

  // response checker sampling mid-cycle where the handshake is settled
  always @(negedge clk) begin
    if (!rst_n) begin
      head_seen = 1'b0;
      resp_held = 1'b0;
    end else if (resp_valid) begin
      check_condition(exp_data_q.size() != 0, "response arrived with no read outstanding");
      if (!head_seen) begin
        check_condition(cycle_count - exp_cycle_q[0] <= READ_LATENCY_MAX,
                        $sformatf("read response came %0d cycles after acceptance",
                                  cycle_count - exp_cycle_q[0]));
        head_seen = 1'b1;
      end
      if (resp_held) begin
        check_value("resp_data (held)", 32'(resp_data), 32'(held_data));
      end
      if (resp_ready) begin
        check_value("resp_data", 32'(resp_data), 32'(exp_data_q[0]));
        void'(exp_data_q.pop_front());
        void'(exp_cycle_q.pop_front());
        head_seen  = 1'b0;
        resp_held  = 1'b0;
        resp_count = resp_count + 1;
      end else begin
        resp_held = 1'b1;
        held_data = resp_data;
      end
    end else begin
      check_condition(!resp_held, "resp_valid dropped before the response was taken");
    end
  end

  // returns just after the accepting edge
  task automatic send_cmd(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data);
    int waited;
    waited      = 0;
    cmd_valid   = 1'b1;
    cmd_wr_en   = wr;
    cmd_addr    = addr;
    cmd_wr_data = data;
    while (!cmd_ready) begin
      next_cycle();
      waited++;
      check_condition(waited <= CMD_WAIT_LIMIT,
                      $sformatf("command not accepted, sequencer in %s", seq_state.name()));
    end
    next_cycle();
    cmd_valid = 1'b0;
    if (wr) begin
      // upper write bits have no data lines behind them
      ref_mem[addr] = RDATA_WIDTH'(data);
    end else begin
      exp_data_q.push_back(DATA_WIDTH'(ref_mem[addr]));
      exp_cycle_q.push_back(cycle_count);
    end
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0) begin
      next_cycle();
      waited++;
      check_condition(waited <= DRAIN_LIMIT, "expected read responses did not arrive");
    end
    // quiet period so a stray response after a write gets caught
    repeat (6) next_cycle();
  endtask

  // a scrambled address or data bus survives read-back but not this word compare
  task automatic compare_chip_contents();
    for (int a = 0; a < MEM_WORDS; a++) begin
      check_value($sformatf("u_sram.mem[%0d]", a), 32'(u_sram.mem[a]), 32'(ref_mem[a]));
    end
  endtask

  task automatic test_reset_state();
    int waited;
    waited = 0;
    check_value("cmd_ready", 32'(cmd_ready), 32'd0);
    check_value("resp_valid", 32'(resp_valid), 32'd0);
    check_value("sram_we_n", 32'(sram_we_n), 32'd1);
    check_value("sram_oe_n", 32'(sram_oe_n), 32'd1);
    check_value("sram_ce_n", 32'(sram_ce_n), 32'd1);
    while (!cmd_ready) begin
      next_cycle();
      waited++;
      check_condition(waited <= 2, "cmd_ready did not rise within two cycles of reset");
    end
  endtask

  task automatic test_write_read();
    for (int i = 0; i < 6; i++) begin
      send_cmd(1'b1, ADDR_WIDTH'(i * 3), DATA_WIDTH'((i + 1) * 32'h1357));
    end
    drain_responses();
    // one read at a time so each latency is seen on its own
    for (int i = 0; i < 6; i++) begin
      send_cmd(1'b0, ADDR_WIDTH'(i * 3), '0);
      drain_responses();
    end
  endtask

  task automatic test_ordering();
    for (int i = 0; i < 8; i++) begin
      send_cmd(1'b1, ADDR_WIDTH'(2 * i + 1), DATA_WIDTH'(32'hb00f + i * 32'h0111));
    end
    for (int i = 0; i < 8; i++) begin
      send_cmd(1'b0, ADDR_WIDTH'(15 - 2 * i), '0);
    end
    drain_responses();
  endtask

  task automatic test_backpressure();
    int                    waited;
    int                    count_before;
    logic [DATA_WIDTH-1:0] first_data;
    waited     = 0;
    resp_ready = 1'b0;
    send_cmd(1'b0, ADDR_WIDTH'(3), '0);
    while (!resp_valid) begin
      next_cycle();
      waited++;
      check_condition(waited <= READ_LATENCY_MAX, "read response never became valid");
    end
    first_data = resp_data;
    // a second read waits at the port while the response is held
    cmd_valid = 1'b1;
    cmd_wr_en = 1'b0;
    cmd_addr  = ADDR_WIDTH'(6);
    repeat (20) begin
      check_value("cmd_ready", 32'(cmd_ready), 32'd0);
      check_value("resp_valid", 32'(resp_valid), 32'd1);
      check_value("resp_data", 32'(resp_data), 32'(first_data));
      next_cycle();
    end
    count_before = resp_count;
    resp_ready   = 1'b1;
    next_cycle();
    check_value("resp_count", 32'(resp_count), 32'(count_before + 1));
    check_value("resp_valid", 32'(resp_valid), 32'd0);
    send_cmd(1'b0, ADDR_WIDTH'(6), '0);
    drain_responses();
  endtask

  task automatic test_random_traffic();
    logic                  wr;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    // every address gets written first so no read sees an empty word
    for (int a = 0; a < MEM_WORDS; a++) begin
      data = DATA_WIDTH'(random_bits(DATA_WIDTH));
      send_cmd(1'b1, ADDR_WIDTH'(a), data);
    end
    for (int n = 0; n < 64; n++) begin
      wr   = 1'(random_bits(1));
      addr = ADDR_WIDTH'(random_bits(ADDR_WIDTH));
      data = '0;
      if (wr) begin
        data = DATA_WIDTH'(random_bits(DATA_WIDTH));
      end
      send_cmd(wr, addr, data);
    end
    drain_responses();
    compare_chip_contents();
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_addr    = '0;
    cmd_wr_en   = 1'b0;
    cmd_wr_data = '0;
    resp_ready  = 1'b1;
    cycle_count = 0;
    resp_count  = 0;
    lfsr_state  = 32'h1ac;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset_state();
    test_write_read();
    test_ordering();
    test_backpressure();
    test_random_traffic();

    if (exp_data_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("ERROR t=%0t %0d read responses never arrived", $time, exp_data_q.size());
      $display("** FAIL **");
      $fatal(1, "responses missing at end of run");
    end
  end

endmodule

/* sram_ctrl.f */
hdl/sram_ctrl_pkg.sv
hdl/sram_cmd_sequencer.sv
hdl/sram_pad_io.sv
hdl/sram_resp_fifo.sv
hdl/sram_ctrl_top.sv
verification/async_sram_model.sv
verification/sram_ctrl_tb.sv

/* Makefile */
# Verilator simulation of the async SRAM controller

VERILATOR ?= verilator
TOP       ?= sram_ctrl_tb
FILELIST  ?= sram_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

# the run passes only if the pass message shows up in its output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
